// ==== src.f ====
ln_pkg.sv
ln_adder_tree.sv
ln_row_buffer.sv
ln_stats.sv
ln_normalizer.sv
layer_norm_top.sv
tb_layer_norm.sv

// ==== Makefile ====
# Verilator build and run for the layer-norm testbench
# any variable can be overridden, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_layer_norm
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_layer_norm.sv ====
module tb_layer_norm;
    import ln_pkg::*;

    logic                  clk;
    logic                  rstn;
    logic                  in_vld;
    data_beat_t            in_data;
    logic                  coef_wr;
    logic [beat_idx_w-1:0] coef_addr;
    coef_beat_t            coef;
    logic [shift_w-1:0]    out_shift;
    logic                  out_shift_vld;
    logic                  out_vld;
    data_beat_t            out_data;
    logic                  out_last;

    integer     seed = 32'hcdac;
    // model state, coefficient table and output scale as last written
    int         gamma_m [row_beats][lanes];
    int         beta_m  [row_beats][lanes];
    int         scale_m;
    data_beat_t row_m   [row_beats];
    // expected beats in output order
    data_beat_t exp_q [$];
    bit         exp_last_q [$];
    data_beat_t exp_beat;
    bit         exp_last;
    bit         in_row;
    int         rows_sent;
    int         rows_done;
    int         beats_checked;
    int         value_errors;
    int         protocol_errors;
    int         timeouts;

    layer_norm_top layer_norm_top_i (
        .clk           (clk),
        .rstn          (rstn),
        .in_vld        (in_vld),
        .in_data       (in_data),
        .coef_wr       (coef_wr),
        .coef_addr     (coef_addr),
        .coef          (coef),
        .out_shift     (out_shift),
        .out_shift_vld (out_shift_vld),
        .out_vld       (out_vld),
        .out_data      (out_data),
        .out_last      (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // half the position of the leading one, zero for zero
    function automatic int std_shift_of(input int var_v);
        int pos;
        int v;
        pos = -1;
        v = var_v;
        while (v != 0) begin
            v = v >> 1;
            pos++;
        end
        return (pos <= 0) ? 0 : pos / 2;
    endfunction

    function automatic int clamp_int8(input int v);
        if (v > 127) begin
            return 127;
        end
        if (v < -128) begin
            return -128;
        end
        return v;
    endfunction

    // inputs change shortly after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    // expected output beats of the row in row_m
    task automatic predict_row();
        int         sum;
        int         mean;
        int         sq_sum;
        int         sh;
        int         c;
        int         v;
        data_beat_t beat;
        sum = 0;
        sq_sum = 0;
        for (int b = 0; b < row_beats; b++) begin
            for (int l = 0; l < lanes; l++) begin
                sum += int'(row_m[b][l]);
            end
        end
        mean = sum >>> elems_log2;
        for (int b = 0; b < row_beats; b++) begin
            for (int l = 0; l < lanes; l++) begin
                c = int'(row_m[b][l]) - mean;
                sq_sum += c * c;
            end
        end
        sh = std_shift_of(sq_sum >> elems_log2);
        for (int b = 0; b < row_beats; b++) begin
            for (int l = 0; l < lanes; l++) begin
                c = int'(row_m[b][l]) - mean;
                v = ((c * gamma_m[b][l]) >>> (sh + scale_m)) + beta_m[b][l];
                beat[l] = data_t'(clamp_int8(v));
            end
            exp_q.push_back(beat);
            exp_last_q.push_back(b == row_beats - 1);
        end
    endtask

    // random gamma and beta, or a fixed gamma with zero beta
    task automatic load_coefs(input bit rand_mode, input int g_fixed);
        coef_beat_t cb;
        for (int b = 0; b < row_beats; b++) begin
            for (int l = 0; l < lanes; l++) begin
                if (rand_mode) begin
                    cb[l].gamma = data_t'($random(seed));
                    cb[l].beta  = data_t'($random(seed));
                end else begin
                    cb[l].gamma = data_t'(g_fixed);
                    cb[l].beta  = '0;
                end
                gamma_m[b][l] = int'(cb[l].gamma);
                beta_m[b][l]  = int'(cb[l].beta);
            end
            coef_wr   = 1'b1;
            coef_addr = beat_idx_w'(b);
            coef      = cb;
            step_cycle();
        end
        coef_wr = 1'b0;
    endtask

    task automatic set_scale(input int s);
        out_shift     = shift_w'(s);
        out_shift_vld = 1'b1;
        scale_m       = s;
        step_cycle();
        out_shift_vld = 1'b0;
    endtask

    task automatic fill_random_row();
        for (int b = 0; b < row_beats; b++) begin
            for (int l = 0; l < lanes; l++) begin
                row_m[b][l] = data_t'($random(seed));
            end
        end
    endtask

    // every element equal, so the variance is zero
    task automatic fill_const_row();
        data_t v;
        v = data_t'($random(seed));
        for (int b = 0; b < row_beats; b++) begin
            for (int l = 0; l < lanes; l++) begin
                row_m[b][l] = v;
            end
        end
    endtask

    // alternating rails, widest spread around the mean
    task automatic fill_extreme_row();
        for (int b = 0; b < row_beats; b++) begin
            for (int l = 0; l < lanes; l++) begin
                row_m[b][l] = ((b * lanes + l) % 2 == 0) ? data_t'(-128) : data_t'(127);
            end
        end
    endtask

    task automatic send_row(input bit gaps);
        for (int b = 0; b < row_beats; b++) begin
            if (gaps) begin
                repeat ($unsigned($random(seed)) % 4) step_cycle();
            end
            in_vld  = 1'b1;
            in_data = row_m[b];
            step_cycle();
            in_vld  = 1'b0;
        end
    endtask

    task automatic end_run();
        int total;
        total = value_errors + protocol_errors + timeouts;
        $display("beats %0d rows %0d value errors %0d protocol errors %0d timeouts %0d",
                 beats_checked, rows_done, value_errors, protocol_errors, timeouts);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic wait_row_end();
        int cycles;
        cycles = 0;
        while (rows_done < rows_sent && cycles < 2000) begin
            step_cycle();
            cycles++;
        end
        if (rows_done < rows_sent) begin
            $display("no out_last within 2000 cycles for row %0d", rows_sent);
            timeouts++;
            end_run();
        end
    endtask

    task automatic run_row(input bit gaps);
        predict_row();
        rows_sent++;
        send_row(gaps);
        wait_row_end();
    endtask

    // outputs sampled on the falling edge, away from the register updates
    always @(negedge clk) begin
        if (rstn && out_vld) begin
            assert (exp_q.size() > 0) else begin
                $display("output beat at time %0t with no beat expected", $time);
                protocol_errors++;
            end
            if (exp_q.size() > 0) begin
                exp_beat = exp_q.pop_front();
                exp_last = exp_last_q.pop_front();
                beats_checked++;
                assert (out_data == exp_beat) else begin
                    $display("[FAIL] %0t out_data %h expected %h", $time, out_data, exp_beat);
                    value_errors++;
                end
                assert (out_last == exp_last) else begin
                    $display("out_last was %0b at time %0t where %0b was expected",
                             out_last, $time, exp_last);
                    protocol_errors++;
                end
            end
            in_row = !out_last;
            if (out_last) begin
                rows_done++;
            end
        end else if (rstn) begin
            // beats of one row come without holes
            assert (!in_row) else begin
                $display("gap inside the output beats of a row at time %0t", $time);
                protocol_errors++;
            end
            in_row = 1'b0;
        end
    end

    initial begin
        rstn          = 1'b0;
        in_vld        = 1'b0;
        in_data       = '0;
        coef_wr       = 1'b0;
        coef_addr     = '0;
        coef          = '0;
        out_shift     = '0;
        out_shift_vld = 1'b0;
        in_row        = 1'b0;
        scale_m       = 0;
        // model table matches the reset table
        for (int b = 0; b < row_beats; b++) begin
            for (int l = 0; l < lanes; l++) begin
                gamma_m[b][l] = 1;
                beta_m[b][l]  = 0;
            end
        end
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        step_cycle();

        // identity coefficients, plain centered and shifted values
        for (int r = 0; r < 3; r++) begin
            fill_random_row();
            run_row(1'b0);
        end
        // per lane, per beat gamma and beta
        load_coefs(1'b1, 0);
        for (int r = 0; r < 3; r++) begin
            fill_random_row();
            run_row(1'b0);
        end
        set_scale(2);
        for (int r = 0; r < 3; r++) begin
            fill_random_row();
            run_row(1'b0);
        end
        // zero variance leaves beta alone
        fill_const_row();
        run_row(1'b0);
        // both saturation rails
        set_scale(0);
        load_coefs(1'b0, 127);
        fill_extreme_row();
        run_row(1'b0);
        load_coefs(1'b0, -128);
        fill_extreme_row();
        run_row(1'b0);
        // idle gaps on input, rows one after another
        load_coefs(1'b1, 0);
        set_scale(1);
        for (int r = 0; r < 6; r++) begin
            fill_random_row();
            run_row(1'b1);
        end

        // catch stray beats after the last row
        repeat (20) step_cycle();
        assert (exp_q.size() == 0) else begin
            $display("%0d expected output beats never arrived", exp_q.size());
            protocol_errors++;
        end
        end_run();
    end

endmodule

// ==== layer_norm_top.sv ====
module layer_norm_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          in_vld,
    input  ln_pkg::data_beat_t            in_data,
    input  logic                          coef_wr,
    input  logic [ln_pkg::beat_idx_w-1:0] coef_addr,
    input  ln_pkg::coef_beat_t            coef,
    input  logic [ln_pkg::shift_w-1:0]    out_shift,
    input  logic                          out_shift_vld,
    output logic                          out_vld,
    output ln_pkg::data_beat_t            out_data,
    output logic                          out_last
);
    import ln_pkg::*;

    logic        wr;
    cent_beat_t  wr_data;
    logic        rd_recirc;
    logic        rd_drain;
    cent_beat_t  rd_data;
    logic        norm_start;
    row_stats_t  stats;
    logic        norm_done;

    // mean and variance passes
    ln_stats u_stats (
        .clk        (clk),
        .rstn       (rstn),
        .in_vld     (in_vld),
        .in_data    (in_data),
        .wr         (wr),
        .wr_data    (wr_data),
        .rd_recirc  (rd_recirc),
        .rd_data    (rd_data),
        .norm_start (norm_start),
        .stats      (stats),
        .norm_done  (norm_done)
    );

    // one row, shared by all three passes
    ln_row_buffer u_row_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr),
        .wr_data   (wr_data),
        .rd_recirc (rd_recirc),
        .rd_drain  (rd_drain),
        .rd_data   (rd_data)
    );

    ln_normalizer u_normalizer (
        .clk           (clk),
        .rstn          (rstn),
        .norm_start    (norm_start),
        .stats         (stats),
        .rd_drain      (rd_drain),
        .rd_data       (rd_data),
        .coef_wr       (coef_wr),
        .coef_addr     (coef_addr),
        .coef          (coef),
        .out_shift     (out_shift),
        .out_shift_vld (out_shift_vld),
        .norm_done     (norm_done),
        .out_vld       (out_vld),
        .out_data      (out_data),
        .out_last      (out_last)
    );

endmodule

// ==== ln_normalizer.sv ====
module ln_normalizer (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          norm_start,
    input  ln_pkg::row_stats_t            stats,
    output logic                          rd_drain,
    input  ln_pkg::cent_beat_t            rd_data,
    input  logic                          coef_wr,
    input  logic [ln_pkg::beat_idx_w-1:0] coef_addr,
    input  ln_pkg::coef_beat_t            coef,
    input  logic [ln_pkg::shift_w-1:0]    out_shift,
    input  logic                          out_shift_vld,
    output logic                          norm_done,
    output logic                          out_vld,
    output ln_pkg::data_beat_t            out_data,
    output logic                          out_last
);
    import ln_pkg::*;

    localparam int prod_w = $bits(cent_t) + $bits(data_t);

    coef_beat_t               coef_tbl [row_beats];
    logic [shift_w-1:0]       std_shift_q;
    logic [shift_w-1:0]       scale_q;
    logic                     draining;
    logic [beat_idx_w-1:0]    rd_idx;
    logic                     rd_q;
    logic [beat_idx_w-1:0]    idx_q;
    logic                     last_q;
    logic                     prod_vld;
    logic                     prod_last;
    logic signed [prod_w-1:0] prod     [lanes];
    data_beat_t               beta_q;
    logic [shift_w:0]         shift_sum;
    logic signed [prod_w-1:0] shifted  [lanes];
    logic signed [prod_w:0]   biased   [lanes];
    data_beat_t               sat;

    assign rd_drain  = draining;
    // done with the last read, the pipe still holds three beats
    assign norm_done = draining && (rd_idx == beat_idx_w'(row_beats - 1));

    // table starts as identity, gamma 1 and beta 0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int b = 0; b < row_beats; b++) begin
                for (int l = 0; l < lanes; l++) begin
                    coef_tbl[b][l].gamma <= data_t'(1);
                    coef_tbl[b][l].beta  <= '0;
                end
            end
        end else if (coef_wr) begin
            coef_tbl[coef_addr] <= coef;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            draining    <= 1'b0;
            std_shift_q <= '0;
            scale_q     <= '0;
            rd_idx      <= '0;
            rd_q        <= 1'b0;
            idx_q       <= '0;
            last_q      <= 1'b0;
            prod_vld    <= 1'b0;
            prod_last   <= 1'b0;
            out_vld     <= 1'b0;
            out_last    <= 1'b0;
        end else begin
            if (norm_start) begin
                draining    <= 1'b1;
                std_shift_q <= stats.std_shift;
            end else if (norm_done) begin
                draining <= 1'b0;
            end
            if (out_shift_vld) begin
                scale_q <= out_shift;
            end
            // beat index wraps back to zero after the row
            if (rd_drain) begin
                rd_idx <= rd_idx + 1'b1;
            end
            rd_q      <= rd_drain;
            idx_q     <= rd_idx;
            last_q    <= norm_done;
            prod_vld  <= rd_q;
            prod_last <= last_q;
            out_vld   <= prod_vld;
            out_last  <= prod_last;
        end
    end

    // shift, offset and clamp to int8
    always_comb begin
        shift_sum = std_shift_q + scale_q;
        for (int l = 0; l < lanes; l++) begin
            shifted[l] = prod[l] >>> shift_sum;
            biased[l]  = shifted[l] + beta_q[l];
            if (biased[l] > 127) begin
                sat[l] = data_t'(127);
            end else if (biased[l] < -128) begin
                sat[l] = data_t'(-128);
            end else begin
                sat[l] = data_t'(biased[l]);
            end
        end
    end

    // product stage sees the buffer data, output stage the product
    always_ff @(posedge clk) begin
        if (rd_q) begin
            for (int l = 0; l < lanes; l++) begin
                prod[l]   <= rd_data[l] * coef_tbl[idx_q][l].gamma;
                beta_q[l] <= coef_tbl[idx_q][l].beta;
            end
        end
        if (prod_vld) begin
            out_data <= sat;
        end
    end

    // next row only starts after this drain ends
    assert property (@(posedge clk) disable iff (!rstn)
        norm_start |-> !draining);

endmodule

// ==== ln_stats.sv ====
module ln_stats (
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_vld,
    input  ln_pkg::data_beat_t in_data,
    output logic               wr,
    output ln_pkg::cent_beat_t wr_data,
    output logic               rd_recirc,
    input  ln_pkg::cent_beat_t rd_data,
    output logic               norm_start,
    output ln_pkg::row_stats_t stats,
    input  logic               norm_done
);
    import ln_pkg::*;

    typedef enum logic [1:0] {
        ph_mean,
        ph_var,
        ph_norm
    } phase_t;

    phase_t                     phase;
    logic [beat_idx_w:0]        in_cnt;
    logic                       in_take;
    logic                       mean_vld;
    logic [acc_w-1:0]           mean_sum;
    logic [beat_idx_w-1:0]      mean_cnt;
    logic [acc_w-1:0]           mean_acc;
    logic [acc_w-1:0]           mean_total;
    logic                       mean_last;
    data_t                      mean;
    logic [beat_idx_w:0]        rd_cnt;
    logic                       rd_q;
    cent_beat_t                 cent;
    logic signed [2*$bits(cent_t)-1:0] sq_full [lanes];
    sq_beat_t                   sq;
    logic                       var_vld;
    logic [acc_w-1:0]           var_sum;
    logic [beat_idx_w-1:0]      var_cnt;
    logic [acc_w-1:0]           var_acc;
    logic [acc_w-1:0]           var_total;
    logic                       var_last;
    logic [acc_w-1:0]           variance;
    logic [shift_w-1:0]         std_shift;

    // inverse std as a shift, half the leading-one position
    // zero variance falls out as zero
    function automatic logic [shift_w-1:0] half_lead(input logic [acc_w-1:0] v);
        logic [shift_w-1:0] pos;
        pos = '0;
        for (int b = 0; b < acc_w; b++) begin
            if (v[b]) begin
                pos = shift_w'(b);
            end
        end
        return pos >> 1;
    endfunction

    // one row of beats per mean pass, extras dropped
    assign in_take = in_vld && (phase == ph_mean) && (in_cnt != row_beats);

    ln_adder_tree #(
        .lane_t (data_t)
    ) u_mean_tree (
        .clk      (clk),
        .rstn     (rstn),
        .in_vld   (in_take),
        .in_lanes (in_data),
        .sum_vld  (mean_vld),
        .sum      (mean_sum)
    );

    assign mean_total = mean_acc + mean_sum;
    assign mean_last  = mean_vld && (mean_cnt == beat_idx_w'(row_beats - 1));

    // variance pass reads the whole row once
    assign rd_recirc = (phase == ph_var) && (rd_cnt != row_beats);

    // buffered beat arrives the cycle after its read
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            cent[i]    = rd_data[i] - cent_t'(mean);
            sq_full[i] = cent[i] * cent[i];
            sq[i]      = sq_t'(sq_full[i]);
        end
    end

    ln_adder_tree #(
        .lane_t (sq_t)
    ) u_var_tree (
        .clk      (clk),
        .rstn     (rstn),
        .in_vld   (rd_q),
        .in_lanes (sq),
        .sum_vld  (var_vld),
        .sum      (var_sum)
    );

    assign var_total = var_acc + var_sum;
    assign var_last  = var_vld && (var_cnt == beat_idx_w'(row_beats - 1));
    assign variance  = var_total >> elems_log2;

    assign stats = '{mean: mean, std_shift: std_shift};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase      <= ph_mean;
            in_cnt     <= '0;
            mean_cnt   <= '0;
            mean_acc   <= '0;
            mean       <= '0;
            rd_cnt     <= '0;
            rd_q       <= 1'b0;
            var_cnt    <= '0;
            var_acc    <= '0;
            std_shift  <= '0;
            norm_start <= 1'b0;
            wr         <= 1'b0;
        end else begin
            rd_q       <= rd_recirc;
            // raw beats in the mean pass, centered beats write back later
            wr         <= in_take | rd_q;
            norm_start <= var_last;
            if (in_take) begin
                in_cnt <= in_cnt + 1'b1;
            end
            if (mean_vld) begin
                mean_cnt <= mean_cnt + 1'b1;
                mean_acc <= mean_last ? '0 : mean_total;
            end
            if (rd_recirc) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (var_vld) begin
                var_cnt <= var_cnt + 1'b1;
                var_acc <= var_last ? '0 : var_total;
            end
            if (var_last) begin
                std_shift <= half_lead(variance);
            end
            case (phase)
                ph_mean: begin
                    if (mean_last) begin
                        phase  <= ph_var;
                        in_cnt <= '0;
                        mean   <= data_t'($signed(mean_total) >>> elems_log2);
                    end
                end
                ph_var: begin
                    // leave once the stats are handed over
                    if (norm_start) begin
                        phase  <= ph_norm;
                        rd_cnt <= '0;
                    end
                end
                ph_norm: begin
                    if (norm_done) begin
                        phase <= ph_mean;
                    end
                end
                default: begin
                    phase <= ph_mean;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < lanes; i++) begin
            wr_data[i] <= in_take ? cent_t'(in_data[i]) : cent[i];
        end
    end

    // buffer only written by the first two passes
    assert property (@(posedge clk) disable iff (!rstn)
        wr |-> (phase == ph_mean || phase == ph_var));

    assert property (@(posedge clk) disable iff (!rstn)
        norm_start |-> (phase == ph_var));

endmodule

// ==== ln_row_buffer.sv ====
module ln_row_buffer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               wr,
    input  ln_pkg::cent_beat_t wr_data,
    input  logic               rd_recirc,
    input  logic               rd_drain,
    output ln_pkg::cent_beat_t rd_data
);
    import ln_pkg::*;

    cent_beat_t             mem [row_beats];
    logic [beat_idx_w-1:0]  wr_ptr;
    logic [beat_idx_w-1:0]  rd_ptr;
    logic [beat_idx_w:0]    count;
    logic                   rd;

    // one read port shared by the variance and drain passes
    assign rd = rd_recirc | rd_drain;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // registered read, data valid the next cycle
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (wr && count == row_beats) |-> rd);

    assert property (@(posedge clk) disable iff (!rstn)
        rd |-> (count != 0));

    assert property (@(posedge clk) disable iff (!rstn)
        !(rd_recirc && rd_drain));

endmodule

// ==== ln_adder_tree.sv ====
module ln_adder_tree #(
    parameter type lane_t = ln_pkg::data_t
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       in_vld,
    input  lane_t [ln_pkg::lanes-1:0]  in_lanes,
    output logic                       sum_vld,
    output logic [ln_pkg::acc_w-1:0]   sum
);
    import ln_pkg::*;

    // lanes widened to the accumulator width
    logic [acc_w-1:0] ext    [lanes];
    // first level of pair sums, registered
    logic [acc_w-1:0] lvl1_q [lanes/2];
    // second level, combinational
    logic [acc_w-1:0] lvl2   [lanes/4];
    logic             lvl1_vld;

    // size cast keeps lane signedness
    // so int8 data sign-extends and squares zero-extend
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            ext[i] = acc_w'(in_lanes[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < lanes / 4; i++) begin
            lvl2[i] = lvl1_q[2*i] + lvl1_q[2*i+1];
        end
    end

    // valid pipeline, two stages
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lvl1_vld <= 1'b0;
            sum_vld  <= 1'b0;
        end else begin
            lvl1_vld <= in_vld;
            sum_vld  <= lvl1_vld;
        end
    end

    // sums only move with their valid
    // back to back beats stay in flight together
    always_ff @(posedge clk) begin
        if (in_vld) begin
            for (int i = 0; i < lanes / 2; i++) begin
                lvl1_q[i] <= ext[2*i] + ext[2*i+1];
            end
        end
        if (lvl1_vld) begin
            // last level closes the tree
            sum <= lvl2[0] + lvl2[1];
        end
    end

endmodule

// ==== ln_pkg.sv ====
package ln_pkg;

    // row geometry
    localparam int lanes = 8;
    // power of two so the mean and the variance come from a shift
    localparam int row_beats = 8;
    localparam int row_elems = lanes * row_beats;
    localparam int elems_log2 = $clog2(row_elems);
    localparam int beat_idx_w = $clog2(row_beats);

    // datapath widths
    localparam int acc_w = 32;
    localparam int shift_w = 5;

    // int8 activation element
    typedef logic signed [7:0] data_t;

    // x minus mean, needs one extra bit
    typedef logic signed [8:0] cent_t;

    // square of a centered element, always positive
    typedef logic [16:0] sq_t;

    typedef data_t [lanes-1:0] data_beat_t;

    // row buffer payload
    typedef cent_t [lanes-1:0] cent_beat_t;

    typedef sq_t [lanes-1:0] sq_beat_t;

    // per-element scale and offset
    typedef struct packed {
        data_t gamma;
        data_t beta;
    } coef_t;

    typedef coef_t [lanes-1:0] coef_beat_t;

    // handed from the stats pass to the normalizer
    typedef struct packed {
        data_t               mean;
        logic [shift_w-1:0]  std_shift;
    } row_stats_t;

endpackage
